/* rtl/tiles_pkg.sv */
package tiles_pkg;

    // pixel port and game value types
    typedef logic [7:0] coord_x_t;
    typedef logic [6:0] coord_y_t;
    typedef logic [2:0] colour_t;   // {r, g, b}
    typedef logic [1:0] lane_t;
    typedef logic [7:0] score_t;
    typedef logic [1:0] lives_t;

    typedef enum logic [1:0] {
        FILL_SCREEN,
        HIT_LINE,
        TILE
    } sweep_kind_t;

    typedef enum logic [3:0] {
        CLEAR,
        LINE,
        NEW_TILE,
        ERASE,
        DRAW,
        WAIT_FRAME,
        JUDGE,
        OVER_FILL,
        OVER_IDLE
    } game_state_t;

    // screen geometry
    localparam int SCREEN_W = 160;
    localparam int SCREEN_H = 120;

    // tiles and lanes
    localparam int TILE_SIZE   = 16;
    localparam int LANE_PITCH  = 40;
    localparam int LANE_OFFSET = 12;   // left edge of lane 0

    // rows that matter to the game
    localparam int HIT_ROW   = 110;   // green line
    localparam int HIT_FIRST = 106;   // window on the tile's top row
    localparam int HIT_LAST  = 118;
    localparam int MISS_ROW  = 120;

    localparam colour_t COL_WHITE = 3'd7;
    localparam colour_t COL_BLACK = 3'd0;
    localparam colour_t COL_GREEN = 3'd2;
    localparam colour_t COL_RED   = 3'd4;

    localparam lives_t     START_LIVES = 2'd3;
    localparam logic [4:0] LFSR_SEED   = 5'h1f;

endpackage

/* rtl/sweep_if.sv */
interface sweep_if;

    // request side, held stable by the FSM around start
    tiles_pkg::sweep_kind_t kind;
    tiles_pkg::coord_x_t    base_x;
    tiles_pkg::coord_y_t    base_y;
    tiles_pkg::colour_t     colour;
    logic                   start;   // one cycle pulse

    // status from the sweeper
    logic                   busy;
    logic                   done;    // comes with the last pixel

    modport fsm (
        output kind, base_x, base_y, colour, start,
        input  busy, done
    );

    modport sweeper (
        input  kind, base_x, base_y, colour, start,
        output busy, done
    );

endinterface

/* rtl/lane_lfsr.sv */
module lane_lfsr (
    input  logic             clk,
    input  logic             resetn,
    input  logic             advance,
    output tiles_pkg::lane_t lane
);

    logic [4:0] lfsr_q;
    logic [4:0] lfsr_next;

    // same feedback chain as the board version
    always_comb begin
        lfsr_next[4] = lfsr_q[4] ^ lfsr_q[1];
        lfsr_next[3] = lfsr_q[3] ^ lfsr_q[0];
        lfsr_next[2] = lfsr_q[2] ^ lfsr_next[4];
        lfsr_next[1] = lfsr_q[1] ^ lfsr_next[3];
        lfsr_next[0] = lfsr_q[0] ^ lfsr_next[2];
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            lfsr_q <= tiles_pkg::LFSR_SEED;
        end else if (advance) begin
            lfsr_q <= lfsr_next;   // one step per tile
        end
    end

    assign lane = lfsr_q[4:3];

endmodule

/* rtl/frame_timer.sv */
module frame_timer #(
    parameter int unsigned FRAME_TICKS = 999999
) (
    input  logic clk,
    input  logic resetn,
    output logic tick
);

    // wide enough to hold the reload value
    logic [$clog2(FRAME_TICKS + 1) - 1:0] count;

    always_ff @(posedge clk) begin
        if (resetn) begin
            count <= $bits(count)'(FRAME_TICKS);
        end else if (count == '0) begin
            count <= $bits(count)'(FRAME_TICKS);
        end else begin
            count <= count - 1'b1;
        end
    end

    // one pulse every FRAME_TICKS+1 clocks
    assign tick = (count == '0);

endmodule

/* rtl/hit_detector.sv */
module hit_detector (
    input  logic                clk,
    input  logic                resetn,
    input  tiles_pkg::lane_t    lane,
    input  tiles_pkg::coord_y_t tile_row,
    input  logic [3:0]          keys,
    output logic                hit
);

    logic in_window;
    logic lane_key;

    assign in_window = (tile_row >= tiles_pkg::coord_y_t'(tiles_pkg::HIT_FIRST))
                    && (tile_row <= tiles_pkg::coord_y_t'(tiles_pkg::HIT_LAST));

    // keys of the other lanes never count
    assign lane_key = keys[lane];

    always_ff @(posedge clk) begin
        if (resetn) begin
            hit <= 1'b0;
        end else begin
            hit <= in_window && lane_key;
        end
    end

endmodule

/* rtl/pixel_sweeper.sv */
module pixel_sweeper (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 pause,
    sweep_if.sweeper             sw,
    output tiles_pkg::coord_x_t  px_x,
    output tiles_pkg::coord_y_t  px_y,
    output tiles_pkg::colour_t   px_colour,
    output logic                 px_plot
);

    tiles_pkg::sweep_kind_t kind_q;
    tiles_pkg::coord_x_t    x0_q;
    tiles_pkg::coord_y_t    y0_q;
    tiles_pkg::colour_t     colour_q;
    tiles_pkg::coord_x_t    cx;
    tiles_pkg::coord_y_t    cy;
    tiles_pkg::coord_x_t    x_last;
    tiles_pkg::coord_y_t    y_last;
    logic                   busy;
    logic                   last_px;
    logic [7:0]             row_sum;   // tile rows run past the screen bottom

    // rectangle extent of the running sweep
    always_comb begin
        case (kind_q)
            tiles_pkg::FILL_SCREEN: begin
                x_last = tiles_pkg::coord_x_t'(tiles_pkg::SCREEN_W - 1);
                y_last = tiles_pkg::coord_y_t'(tiles_pkg::SCREEN_H - 1);
            end
            tiles_pkg::HIT_LINE: begin
                x_last = tiles_pkg::coord_x_t'(tiles_pkg::SCREEN_W - 1);
                y_last = '0;
            end
            default: begin
                x_last = tiles_pkg::coord_x_t'(tiles_pkg::TILE_SIZE - 1);
                y_last = tiles_pkg::coord_y_t'(tiles_pkg::TILE_SIZE - 1);
            end
        endcase
    end

    assign row_sum = {1'b0, y0_q} + {1'b0, cy};
    assign last_px = (cx == x_last) && (cy == y_last);

    assign px_x      = x0_q + cx;
    assign px_y      = row_sum[6:0];
    assign px_colour = colour_q;
    assign px_plot   = busy && !pause && (row_sum < 8'(tiles_pkg::SCREEN_H));   // clip

    assign sw.busy = busy;
    assign sw.done = busy && !pause && last_px;

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy   <= 1'b0;
            kind_q <= tiles_pkg::FILL_SCREEN;
            cx     <= '0;
            cy     <= '0;
        end else if (!busy) begin
            if (sw.start) begin
                busy   <= 1'b1;
                kind_q <= sw.kind;
                cx     <= '0;
                cy     <= '0;
            end
        end else if (!pause) begin
            // row-major walk
            if (cx == x_last) begin
                cx <= '0;
                if (cy == y_last) begin
                    busy <= 1'b0;
                end else begin
                    cy <= cy + 1'b1;
                end
            end else begin
                cx <= cx + 1'b1;
            end
        end
    end

    // rectangle origin and colour, taken with the request
    always_ff @(posedge clk) begin
        if (!busy && sw.start) begin
            x0_q     <= sw.base_x;
            y0_q     <= sw.base_y;
            colour_q <= sw.colour;
        end
    end

endmodule

/* rtl/game_fsm.sv */
module game_fsm (
    input  logic                clk,
    input  logic                resetn,
    input  logic                pause,
    input  logic                endless,
    input  logic                tick,
    input  logic                hit,
    input  tiles_pkg::lane_t    lane,
    sweep_if.fsm                sw,
    output logic                advance,
    output tiles_pkg::coord_y_t tile_row,
    output tiles_pkg::score_t   score,
    output tiles_pkg::lives_t   lives,
    output logic                game_over
);

    tiles_pkg::game_state_t state;
    tiles_pkg::coord_x_t    tile_x;
    logic                   start_q;
    logic                   issued;      // sweep of this state already requested
    logic                   tile_hit;
    logic                   first_hit;   // endless mode only takes points after this
    logic                   sweeping;
    logic                   in_tile;

    // lane stays put between two advances
    assign tile_x = tiles_pkg::coord_x_t'(lane * tiles_pkg::LANE_PITCH + tiles_pkg::LANE_OFFSET);

    assign sweeping = state inside {tiles_pkg::CLEAR, tiles_pkg::LINE, tiles_pkg::ERASE,
                                    tiles_pkg::DRAW, tiles_pkg::OVER_FILL};
    assign in_tile   = state inside {tiles_pkg::ERASE, tiles_pkg::DRAW, tiles_pkg::WAIT_FRAME};
    assign advance   = (state == tiles_pkg::NEW_TILE) && !pause;
    assign game_over = state inside {tiles_pkg::OVER_FILL, tiles_pkg::OVER_IDLE};
    assign sw.start  = start_q;

    // what each state puts on the screen
    always_comb begin
        sw.kind   = tiles_pkg::FILL_SCREEN;
        sw.base_x = '0;
        sw.base_y = '0;
        sw.colour = tiles_pkg::COL_WHITE;
        case (state)
            tiles_pkg::LINE: begin
                sw.kind   = tiles_pkg::HIT_LINE;
                sw.base_y = tiles_pkg::coord_y_t'(tiles_pkg::HIT_ROW);
                sw.colour = tiles_pkg::COL_GREEN;
            end
            tiles_pkg::ERASE: begin
                sw.kind   = tiles_pkg::TILE;
                sw.base_x = tile_x;
                sw.base_y = tile_row;
            end
            tiles_pkg::DRAW: begin
                sw.kind   = tiles_pkg::TILE;
                sw.base_x = tile_x;
                sw.base_y = tile_row;
                sw.colour = tiles_pkg::COL_BLACK;
            end
            tiles_pkg::OVER_FILL: sw.colour = tiles_pkg::COL_RED;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state     <= tiles_pkg::CLEAR;
            start_q   <= 1'b0;
            issued    <= 1'b0;
            tile_hit  <= 1'b0;
            first_hit <= 1'b0;
            tile_row  <= '0;
            score     <= '0;
            lives     <= tiles_pkg::START_LIVES;
        end else begin
            start_q <= 1'b0;
            if (!pause) begin
                if (in_tile && hit) begin
                    // a running tile sweep just finishes on its own
                    tile_hit <= 1'b1;
                    issued   <= 1'b0;
                    state    <= tiles_pkg::JUDGE;
                end else if (sweeping && !issued) begin
                    if (!sw.busy) begin
                        start_q <= 1'b1;
                        issued  <= 1'b1;
                    end
                end else begin
                    if (sw.done) issued <= 1'b0;
                    case (state)
                        tiles_pkg::CLEAR: if (sw.done) state <= tiles_pkg::LINE;
                        tiles_pkg::LINE:  if (sw.done) state <= tiles_pkg::NEW_TILE;
                        tiles_pkg::NEW_TILE: begin
                            tile_row <= '0;
                            state    <= tiles_pkg::DRAW;   // first step skips the erase
                        end
                        tiles_pkg::ERASE: begin
                            if (sw.done) begin
                                tile_row <= tile_row + 1'b1;
                                state    <= tiles_pkg::DRAW;
                            end
                        end
                        tiles_pkg::DRAW: begin
                            if (sw.done) begin
                                if (tile_row == tiles_pkg::coord_y_t'(tiles_pkg::MISS_ROW)) begin
                                    tile_hit <= 1'b0;
                                    state    <= tiles_pkg::JUDGE;
                                end else begin
                                    state <= tiles_pkg::WAIT_FRAME;
                                end
                            end
                        end
                        tiles_pkg::WAIT_FRAME: if (tick) state <= tiles_pkg::ERASE;
                        tiles_pkg::JUDGE: begin
                            tile_row <= '0;   // keeps a stale hit out of the next tile
                            state    <= tiles_pkg::CLEAR;
                            if (tile_hit) begin
                                if (score != '1) score <= score + 1'b1;
                                first_hit <= 1'b1;
                            end else if (!endless) begin
                                lives <= lives - 1'b1;
                                if (lives == tiles_pkg::lives_t'(1)) state <= tiles_pkg::OVER_FILL;
                            end else if (first_hit) begin
                                if (score != '0) score <= score - 1'b1;
                                else state <= tiles_pkg::OVER_FILL;
                            end
                        end
                        tiles_pkg::OVER_FILL: if (sw.done) state <= tiles_pkg::OVER_IDLE;
                        default: ;   // over_idle waits for reset
                    endcase
                end
            end
        end
    end

endmodule

/* rtl/score_display.sv */
module score_display (
    input  tiles_pkg::score_t score,
    input  tiles_pkg::lives_t lives,
    input  logic              endless,
    output logic [6:0]        hex_lo,
    output logic [6:0]        hex_hi,
    output logic [2:0]        lives_leds
);

    // active low segments, g down to a
    function automatic logic [6:0] seg7(input logic [3:0] digit);
        case (digit)
            4'h0: seg7 = 7'b100_0000;
            4'h1: seg7 = 7'b111_1001;
            4'h2: seg7 = 7'b010_0100;
            4'h3: seg7 = 7'b011_0000;
            4'h4: seg7 = 7'b001_1001;
            4'h5: seg7 = 7'b001_0010;
            4'h6: seg7 = 7'b000_0010;
            4'h7: seg7 = 7'b111_1000;
            4'h8: seg7 = 7'b000_0000;
            4'h9: seg7 = 7'b001_1000;
            4'ha: seg7 = 7'b000_1000;
            4'hb: seg7 = 7'b000_0011;
            4'hc: seg7 = 7'b100_0110;
            4'hd: seg7 = 7'b010_0001;
            4'he: seg7 = 7'b000_0110;
            default: seg7 = 7'b000_1110;
        endcase
    endfunction

    assign hex_lo = seg7(score[3:0]);
    assign hex_hi = seg7(score[7:4]);

    // thermometer bar, dark in endless mode
    always_comb begin
        case (lives)
            2'd0:    lives_leds = 3'b000;
            2'd1:    lives_leds = 3'b001;
            2'd2:    lives_leds = 3'b011;
            default: lives_leds = 3'b111;
        endcase
        if (endless) lives_leds = 3'b000;
    end

endmodule

/* rtl/tiles_top.sv */
module tiles_top #(
    parameter int unsigned FRAME_TICKS = 999999
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                pause,
    input  logic                endless,
    input  logic [3:0]          keys,
    output tiles_pkg::coord_x_t px_x,
    output tiles_pkg::coord_y_t px_y,
    output tiles_pkg::colour_t  px_colour,
    output logic                px_plot,
    output logic [6:0]          hex_lo,
    output logic [6:0]          hex_hi,
    output logic [2:0]          lives_leds,
    output logic                game_over
);

    sweep_if sw_bus ();

    logic                advance;
    logic                tick;
    logic                hit;
    tiles_pkg::lane_t    lane;
    tiles_pkg::coord_y_t tile_row;
    tiles_pkg::score_t   score;
    tiles_pkg::lives_t   lives;

    lane_lfsr lane_lfsr_inst (
        .clk     (clk),
        .resetn  (resetn),
        .advance (advance),
        .lane    (lane)
    );

    frame_timer #(
        .FRAME_TICKS (FRAME_TICKS)
    ) frame_timer_inst (
        .clk    (clk),
        .resetn (resetn),
        .tick   (tick)
    );

    hit_detector hit_detector_inst (
        .clk      (clk),
        .resetn   (resetn),
        .lane     (lane),
        .tile_row (tile_row),
        .keys     (keys),
        .hit      (hit)
    );

    pixel_sweeper pixel_sweeper_inst (
        .clk       (clk),
        .resetn    (resetn),
        .pause     (pause),
        .sw        (sw_bus.sweeper),
        .px_x      (px_x),
        .px_y      (px_y),
        .px_colour (px_colour),
        .px_plot   (px_plot)
    );

    game_fsm game_fsm_inst (
        .clk       (clk),
        .resetn    (resetn),
        .pause     (pause),
        .endless   (endless),
        .tick      (tick),
        .hit       (hit),
        .lane      (lane),
        .sw        (sw_bus.fsm),
        .advance   (advance),
        .tile_row  (tile_row),
        .score     (score),
        .lives     (lives),
        .game_over (game_over)
    );

    score_display score_display_inst (
        .score      (score),
        .lives      (lives),
        .endless    (endless),
        .hex_lo     (hex_lo),
        .hex_hi     (hex_hi),
        .lives_leds (lives_leds)
    );

endmodule

/* testbench/tiles_chk.sv */
module tiles_chk (
    input logic                clk,
    input logic                resetn,
    input logic                pause,
    input logic                px_plot,
    input tiles_pkg::coord_x_t px_x,
    input tiles_pkg::coord_y_t px_y,
    input logic                start,
    input logic                busy
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;   // failed assertions so far

    plot_on_screen: assert property (@(posedge clk) disable iff (resetn)
        px_plot |-> (px_x < tiles_pkg::SCREEN_W) && (px_y < tiles_pkg::SCREEN_H))
    else begin
        $error("pixel plotted outside the screen");
        fail_count++;
    end

    // requests only reach an idle sweeper
    start_when_idle: assert property (@(posedge clk) disable iff (resetn)
        start |-> !busy)
    else begin
        $error("sweep started while the sweeper was busy");
        fail_count++;
    end

    // the walk keeps its place while paused
    hold_in_pause: assert property (@(posedge clk) disable iff (resetn)
        pause && busy |=> $stable(px_x) && $stable(px_y))
    else begin
        $error("sweep position moved while paused");
        fail_count++;
    end

endmodule

bind pixel_sweeper tiles_chk pixel_chk_inst (
    .clk     (clk),
    .resetn  (resetn),
    .pause   (pause),
    .px_plot (px_plot),
    .px_x    (px_x),
    .px_y    (px_y),
    .start   (sw.start),
    .busy    (sw.busy)
);

/* testbench/tiles_tb.sv */
module tiles_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_TICKS = 20;
    localparam int NUM_SCEN    = 2;
    localparam int MAX_TILES   = 4;
    localparam int PRESS_ROW   = 108;
    localparam int PAUSE_ROW   = 40;
    localparam int PAUSE_LEN   = 500;
    localparam int FILL_PIXELS = tiles_pkg::SCREEN_W * tiles_pkg::SCREEN_H;
    // slowest tile takes two fills, the line and every fall step down to the miss row
    localparam int STEP_CYCLES = 2 * tiles_pkg::TILE_SIZE * tiles_pkg::TILE_SIZE
                               + FRAME_TICKS + 10;
    localparam int TILE_CYCLES = 2 * FILL_PIXELS + tiles_pkg::SCREEN_W
                               + (tiles_pkg::MISS_ROW + 1) * STEP_CYCLES;

    logic                clk;
    logic                resetn;
    logic                pause;
    logic                endless;
    logic [3:0]          keys;
    tiles_pkg::coord_x_t px_x;
    tiles_pkg::coord_y_t px_y;
    tiles_pkg::colour_t  px_colour;
    logic                px_plot;
    logic [6:0]          hex_lo;
    logic [6:0]          hex_hi;
    logic [2:0]          lives_leds;
    logic                game_over;

    // rows are scenarios and columns are tiles
    int scen_endless [NUM_SCEN] = '{0, 1};
    int scen_pause   [NUM_SCEN] = '{1, 0};   // pause inside the first tile
    int scen_tiles   [NUM_SCEN] = '{4, 4};
    int tile_hit  [NUM_SCEN][MAX_TILES] = '{'{1, 0, 0, 0}, '{0, 1, 0, 0}};
    int exp_score [NUM_SCEN][MAX_TILES] = '{'{1, 1, 1, 1}, '{0, 1, 0, 0}};
    int exp_lives [NUM_SCEN][MAX_TILES] = '{'{3, 2, 1, 0}, '{3, 3, 3, 3}};
    int exp_over  [NUM_SCEN][MAX_TILES] = '{'{0, 0, 0, 1}, '{0, 0, 0, 1}};

    // active low digits with segment g in the top bit
    logic [6:0] seg_table [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                   7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

    logic [31:0]        noise_state = 32'd77968;
    logic [1:0]         cur_lane    = 2'd0;
    logic               press       = 1'b0;
    int                 lane_lo     = 0;
    int                 mismatches  = 0;
    int                 tiles_played = 0;
    bit                 covered [FILL_PIXELS];

    // pixel monitor state
    tiles_pkg::colour_t prev_colour = tiles_pkg::COL_WHITE;
    tiles_pkg::colour_t fill_colour = tiles_pkg::COL_WHITE;
    int                 black_top    = 0;
    int                 black_events = 0;
    int                 fill_events  = 0;

    tiles_top #(
        .FRAME_TICKS (FRAME_TICKS)
    ) tiles_top_inst (
        .clk        (clk),
        .resetn     (resetn),
        .pause      (pause),
        .endless    (endless),
        .keys       (keys),
        .px_x       (px_x),
        .px_y       (px_y),
        .px_colour  (px_colour),
        .px_plot    (px_plot),
        .hex_lo     (hex_lo),
        .hex_hi     (hex_hi),
        .lives_leds (lives_leds),
        .game_over  (game_over)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] galois_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    // lane generator of the game written out bit by bit
    function automatic logic [4:0] next_lane_state(input logic [4:0] s);
        logic [4:0] n;
        n[4] = s[4] ^ s[1];
        n[3] = s[3] ^ s[0];
        n[2] = s[2] ^ s[4] ^ s[1];
        n[1] = s[1] ^ s[3] ^ s[0];
        n[0] = s[0] ^ s[2] ^ s[4] ^ s[1];
        return n;
    endfunction

    function automatic logic [2:0] lives_bar(input int lives);
        return 3'((1 << lives) - 1);   // thermometer
    endfunction

    // random presses on the lanes the tile is not in
    always @(posedge clk) begin : key_driver
        logic [3:0] k;
        for (int i = 0; i < 4; i++) begin
            if (i == cur_lane) begin
                k[i] = press;
            end else begin
                noise_state = galois_next(noise_state);
                k[i] = noise_state[0];
            end
        end
        keys <= k;
    end

    task automatic report_mismatch(input string msg);
        mismatches++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    task automatic sample_pixel();
        if (px_plot) begin
            if (px_colour == tiles_pkg::COL_BLACK) begin
                assert (px_x >= lane_lo && px_x < lane_lo + tiles_pkg::TILE_SIZE) else
                    report_mismatch($sformatf("tile pixel x %0d outside lane %0d", px_x, cur_lane));
                if (prev_colour != tiles_pkg::COL_BLACK) begin
                    black_top = px_y;   // first pixel of a draw is its top row
                    black_events++;
                end
            end
            if (px_x == 0 && px_y == 0) begin
                fill_colour = px_colour;
                fill_events++;
            end
            prev_colour = px_colour;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        sample_pixel();
    endtask

    task automatic apply_reset(input int mode);
        @(posedge clk);
        resetn  <= 1'b1;
        pause   <= 1'b0;
        endless <= (mode != 0);
        press = 1'b0;
        prev_colour = tiles_pkg::COL_WHITE;
        repeat (5) @(posedge clk);
        resetn <= 1'b0;
    endtask

    task automatic check_fill(input tiles_pkg::colour_t colour, input int seen);
        int n;
        int idx;
        for (int i = 0; i < FILL_PIXELS; i++) covered[i] = 1'b0;
        covered[0] = (seen != 0);   // origin already taken by the monitor
        n = seen;
        while (n < FILL_PIXELS) begin
            next_cycle();
            if (px_plot) begin
                idx = px_y * tiles_pkg::SCREEN_W + px_x;
                assert (px_colour == colour) else
                    report_mismatch($sformatf("fill pixel colour %0d, expected %0d",
                                              px_colour, colour));
                assert (idx < FILL_PIXELS && !covered[idx]) else
                    report_mismatch($sformatf("fill pixel (%0d,%0d) repeated", px_x, px_y));
                if (idx < FILL_PIXELS) covered[idx] = 1'b1;
                n++;
            end
        end
    endtask

    task automatic check_hit_line();
        int n;
        n = 0;
        while (n < tiles_pkg::SCREEN_W) begin
            next_cycle();
            if (px_plot) begin
                assert (px_colour == tiles_pkg::COL_GREEN && px_y == tiles_pkg::HIT_ROW
                        && px_x == n) else
                    report_mismatch($sformatf("line pixel (%0d,%0d) colour %0d, expected x %0d",
                                              px_x, px_y, px_colour, n));
                n++;
            end
        end
    endtask

    task automatic hold_pause();
        logic [6:0] lo_before;
        logic [6:0] hi_before;
        logic [2:0] leds_before;
        int         blacks_before;
        lo_before   = hex_lo;
        hi_before   = hex_hi;
        leds_before = lives_leds;
        @(posedge clk);
        pause <= 1'b1;
        repeat (PAUSE_LEN) begin
            next_cycle();
            assert (!px_plot) else report_mismatch("pixel plotted during pause");
            assert (hex_lo == lo_before && hex_hi == hi_before && lives_leds == leds_before)
                else report_mismatch("score or lives moved during pause");
        end
        @(posedge clk);
        pause <= 1'b0;
        blacks_before = black_events;
        while (black_events == blacks_before) next_cycle();
        assert (black_top == PAUSE_ROW + 1) else   // same tile one row further down
            report_mismatch($sformatf("tile resumed at row %0d, expected %0d",
                                      black_top, PAUSE_ROW + 1));
    endtask

    task automatic play_tile(input int s, input int k);
        int fills_at_start;
        int blacks_seen;
        fills_at_start = fill_events;
        blacks_seen    = black_events;
        while (fill_events == fills_at_start) begin
            next_cycle();
            if (black_events != blacks_seen) begin
                blacks_seen = black_events;
                if (tile_hit[s][k] != 0 && black_top == PRESS_ROW) press = 1'b1;
                if (scen_pause[s] != 0 && k == 0 && black_top == PAUSE_ROW) begin
                    hold_pause();
                    blacks_seen = black_events;
                end
            end
        end
        press = 1'b0;
        tiles_played++;
    endtask

    task automatic check_status(input int s, input int k);
        int         sc;
        logic [2:0] leds;
        sc   = exp_score[s][k];
        leds = (scen_endless[s] != 0) ? 3'b000 : lives_bar(exp_lives[s][k]);
        assert (hex_lo == seg_table[sc % 16] && hex_hi == seg_table[sc / 16]) else
            report_mismatch($sformatf("scenario %0d tile %0d digits %h %h, score %0d expected",
                                      s, k, hex_hi, hex_lo, sc));
        assert (lives_leds == leds) else
            report_mismatch($sformatf("scenario %0d tile %0d lives bar %b, expected %b",
                                      s, k, lives_leds, leds));
        assert (game_over == (exp_over[s][k] != 0)) else
            report_mismatch($sformatf("scenario %0d tile %0d game_over %b", s, k, game_over));
        assert (fill_colour == ((exp_over[s][k] != 0) ? tiles_pkg::COL_RED
                                                      : tiles_pkg::COL_WHITE)) else
            report_mismatch($sformatf("scenario %0d tile %0d screen fill colour %0d",
                                      s, k, fill_colour));
    endtask

    initial begin : main
        logic [4:0] lane_state;
        int         last;
        int         chk_fails;
        resetn  = 1'b1;
        pause   = 1'b0;
        endless = 1'b0;
        keys    = 4'b0000;
        for (int s = 0; s < NUM_SCEN; s++) begin
            apply_reset(scen_endless[s]);
            lane_state = tiles_pkg::LFSR_SEED;
            check_fill(tiles_pkg::COL_WHITE, 0);
            check_hit_line();
            for (int k = 0; k < scen_tiles[s]; k++) begin
                lane_state = next_lane_state(lane_state);
                cur_lane   = lane_state[4:3];
                lane_lo    = cur_lane * tiles_pkg::LANE_PITCH + tiles_pkg::LANE_OFFSET;
                play_tile(s, k);
                check_status(s, k);
            end
            last = scen_tiles[s] - 1;
            if (exp_over[s][last] != 0 && fill_colour == tiles_pkg::COL_RED) begin
                check_fill(tiles_pkg::COL_RED, 1);
            end
        end
        chk_fails = tiles_top_inst.pixel_sweeper_inst.pixel_chk_inst.fail_count;
        $display("Summary: %0d tiles played, %0d mismatches, %0d assertion failures",
                 tiles_played, mismatches, chk_fails);
        if (mismatches == 0 && chk_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int total;
        total = 0;
        for (int s = 0; s < NUM_SCEN; s++) total += scen_tiles[s];
        repeat (total * TILE_CYCLES + NUM_SCEN * (PAUSE_LEN + 100)) @(posedge clk);
        $display("Timeout: the game did not finish its %0d tiles in time", total);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* filelist.f */
rtl/tiles_pkg.sv
rtl/sweep_if.sv
rtl/lane_lfsr.sv
rtl/frame_timer.sv
rtl/hit_detector.sv
rtl/pixel_sweeper.sv
rtl/game_fsm.sv
rtl/score_display.sv
rtl/tiles_top.sv
testbench/tiles_chk.sv
testbench/tiles_tb.sv

/* Bender.yml */
package:
  name: tiles

sources:
  - files:
      - rtl/tiles_pkg.sv
      - rtl/sweep_if.sv
      - rtl/lane_lfsr.sv
      - rtl/frame_timer.sv
      - rtl/hit_detector.sv
      - rtl/pixel_sweeper.sv
      - rtl/game_fsm.sv
      - rtl/score_display.sv
      - rtl/tiles_top.sv
  - target: test
    files:
      - testbench/tiles_chk.sv
      - testbench/tiles_tb.sv
